//--- verilog/fcpu_settings.svh
`ifndef FCPU_SETTINGS_SVH
`define FCPU_SETTINGS_SVH

// code address, byte addressed
`define FCPU_ADDR_W       15
// one instruction per word
`define FCPU_DATA_W       32

// opcode sits in the top bits, target in the low bits
`define FCPU_OP_W         6
`define FCPU_TARGET_W     15

// queue slots, also the limit on reads in flight
`define FCPU_FETCH_DEPTH  4
// bytes per instruction
`define FCPU_PC_STEP      4

`endif

//--- verilog/fcpu_pkg.sv
`include "fcpu_settings.svh"

package fcpu_pkg;

   // code address
   typedef logic [`FCPU_ADDR_W-1:0] pc_t;

   // raw instruction word
   typedef logic [`FCPU_DATA_W-1:0] inst_t;

   // opcode field
   typedef logic [`FCPU_OP_W-1:0] opcode_t;

   // fetch queue slot index
   typedef logic [1:0] slot_idx_t;

   // control transfer opcodes
   localparam opcode_t op_jmp = 6'h02;
   localparam opcode_t op_beq = 6'h04;
   localparam opcode_t op_blt = 6'h05;

   // address generator FSM
   typedef enum logic [1:0] {
      fetch_idle,
      fetch_request,
      fetch_hold
   } fetch_state_t;

   // issue stage FSM
   typedef enum logic [1:0] {
      issue_wait,
      issue_offer,
      issue_drop
   } issue_state_t;

endpackage

//--- verilog/fetch_addr_gen.sv
`timescale 1ns/100ps
`include "fcpu_settings.svh"

module fetch_addr_gen (
   input  logic          clk,
   input  logic          nrst,
   input  logic          i_alloc_ok,
   input  logic          i_redirect_valid,
   input  fcpu_pkg::pc_t i_redirect_pc,
   input  logic          i_jump_valid,
   input  fcpu_pkg::pc_t i_jump_pc,
   output fcpu_pkg::pc_t o_cram_araddr,
   output logic          o_cram_arvalid,
   input  logic          i_cram_arready,
   output logic          o_req_fire
);
   import fcpu_pkg::*;

   fetch_state_t state;
   fetch_state_t state_n;
   pc_t          fetch_pc;
   pc_t          fetch_pc_n;
   pc_t          held_pc;
   pc_t          held_pc_n;
   logic         redir;
   pc_t          redir_pc;

   // core redirect wins over a jump from the issue stage
   assign redir    = i_redirect_valid | i_jump_valid;
   assign redir_pc = i_redirect_valid ? i_redirect_pc : i_jump_pc;

   // a read goes out whenever a queue slot is free
   assign o_cram_arvalid = (state != fetch_idle) && i_alloc_ok;
   assign o_cram_araddr  = fetch_pc;
   assign o_req_fire     = o_cram_arvalid && i_cram_arready;

   always_comb begin
      state_n    = state;
      fetch_pc_n = fetch_pc;
      held_pc_n  = held_pc;
      case (state)
         fetch_idle: begin
            state_n = fetch_request;
            if (redir) begin
               fetch_pc_n = redir_pc;
            end
         end
         fetch_request: begin
            if (redir) begin
               if (o_cram_arvalid && !i_cram_arready) begin
                  // address already on the bus, park the new pc
                  state_n   = fetch_hold;
                  held_pc_n = redir_pc;
               end else begin
                  fetch_pc_n = redir_pc;
               end
            end else if (o_req_fire) begin
               fetch_pc_n = fetch_pc + pc_t'(`FCPU_PC_STEP);
            end
         end
         fetch_hold: begin
            // stale read still pending, araddr must not move
            if (o_req_fire) begin
               state_n    = fetch_request;
               fetch_pc_n = redir ? redir_pc : held_pc;
            end else if (redir) begin
               held_pc_n = redir_pc;
            end
         end
         default: begin
            state_n = fetch_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state    <= fetch_idle;
         fetch_pc <= '0;
      end else begin
         state    <= state_n;
         fetch_pc <= fetch_pc_n;
      end
   end

   // target parked during hold
   always_ff @(posedge clk) begin
      held_pc <= held_pc_n;
   end

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/100ps
`include "fcpu_settings.svh"

module fetch_queue (
   input  logic            clk,
   input  logic            nrst,
   input  logic            i_req_fire,
   input  fcpu_pkg::pc_t   i_req_pc,
   input  logic            i_req_taken,
   input  fcpu_pkg::inst_t i_cram_rdata,
   input  logic            i_cram_rvalid,
   output logic            o_cram_rready,
   input  logic            i_flush,
   input  logic            i_pop,
   output logic            o_alloc_ok,
   output logic            o_head_valid,
   output logic            o_head_live,
   output fcpu_pkg::pc_t   o_head_pc,
   output fcpu_pkg::inst_t o_head_word,
   output logic            o_head_taken
);
   import fcpu_pkg::*;

   localparam int cnt_w = $clog2(`FCPU_FETCH_DEPTH + 1);
   localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`FCPU_FETCH_DEPTH);

   // per slot payload
   pc_t   ent_pc    [`FCPU_FETCH_DEPTH];
   inst_t ent_word  [`FCPU_FETCH_DEPTH];
   logic  ent_taken [`FCPU_FETCH_DEPTH];

   // per slot flags
   logic [`FCPU_FETCH_DEPTH-1:0] ent_alloc;
   logic [`FCPU_FETCH_DEPTH-1:0] ent_filled;
   logic [`FCPU_FETCH_DEPTH-1:0] ent_live;

   slot_idx_t        alloc_ptr;
   slot_idx_t        fill_ptr;
   slot_idx_t        head_ptr;
   logic [cnt_w-1:0] count;
   logic             rready_q;
   logic             kill_next;
   logic             fill;

   function automatic slot_idx_t next_idx(input slot_idx_t idx);
      if (idx == slot_idx_t'(`FCPU_FETCH_DEPTH - 1)) begin
         return '0;
      end
      return idx + 1'b1;
   endfunction

   // rready rises together with the generator leaving idle
   assign o_cram_rready = rready_q;
   assign o_alloc_ok    = rready_q && (count != full_cnt);
   assign fill          = i_cram_rvalid && rready_q;

   assign o_head_valid = ent_alloc[head_ptr] && ent_filled[head_ptr];
   assign o_head_live  = ent_live[head_ptr];
   assign o_head_pc    = ent_pc[head_ptr];
   assign o_head_word  = ent_word[head_ptr];
   assign o_head_taken = ent_taken[head_ptr];

   always_ff @(posedge clk) begin
      if (nrst) begin
         ent_alloc  <= '0;
         ent_filled <= '0;
         ent_live   <= '0;
         alloc_ptr  <= '0;
         fill_ptr   <= '0;
         head_ptr   <= '0;
         count      <= '0;
         rready_q   <= 1'b0;
         kill_next  <= 1'b0;
      end else begin
         rready_q <= 1'b1;
         if (i_flush) begin
            ent_live <= '0;
         end
         // slot taken on the AR handshake
         if (i_req_fire) begin
            ent_alloc[alloc_ptr]  <= 1'b1;
            ent_filled[alloc_ptr] <= 1'b0;
            ent_live[alloc_ptr]   <= !(i_flush || kill_next);
            alloc_ptr             <= next_idx(alloc_ptr);
         end
         // responses arrive in request order
         if (fill) begin
            ent_filled[fill_ptr] <= 1'b1;
            fill_ptr             <= next_idx(fill_ptr);
         end
         if (i_pop) begin
            ent_alloc[head_ptr]  <= 1'b0;
            ent_filled[head_ptr] <= 1'b0;
            head_ptr             <= next_idx(head_ptr);
         end
         // flush while AR is pending, that read belongs to the old path
         if (i_req_fire) begin
            kill_next <= 1'b0;
         end else if (i_flush && o_alloc_ok) begin
            kill_next <= 1'b1;
         end
         case ({i_req_fire, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_req_fire) begin
         ent_pc[alloc_ptr]    <= i_req_pc;
         ent_taken[alloc_ptr] <= i_req_taken;
      end
      if (fill) begin
         ent_word[fill_ptr] <= i_cram_rdata;
      end
   end

endmodule

//--- verilog/inst_issue.sv
`timescale 1ns/100ps
`include "fcpu_settings.svh"

module inst_issue (
   input  logic            clk,
   input  logic            nrst,
   input  logic            i_head_valid,
   input  logic            i_head_live,
   input  fcpu_pkg::pc_t   i_head_pc,
   input  fcpu_pkg::inst_t i_head_word,
   input  logic            i_head_taken,
   output logic            o_pop,
   output logic            o_inst_valid,
   output fcpu_pkg::pc_t   o_inst_pc,
   output fcpu_pkg::inst_t o_inst_word,
   output logic            o_inst_taken,
   input  logic            i_inst_ready,
   input  logic            i_redirect_valid,
   output logic            o_jump_valid,
   output fcpu_pkg::pc_t   o_jump_pc
);
   import fcpu_pkg::*;

   issue_state_t state;
   issue_state_t state_n;
   logic         accept;
   logic         load_ok;
   logic         load;
   opcode_t      opcode;
   logic         is_branch;

   assign o_inst_valid = (state == issue_offer);
   assign accept       = o_inst_valid && i_inst_ready;
   // no loading from a path the core is abandoning
   assign load_ok      = i_head_valid && i_head_live && !i_redirect_valid;

   // control transfer decode on the offered word
   assign opcode    = opcode_t'(o_inst_word[`FCPU_DATA_W-1 -: `FCPU_OP_W]);
   assign is_branch = (opcode == op_beq) || (opcode == op_blt);
   assign o_jump_valid = accept && ((opcode == op_jmp) || (is_branch && o_inst_taken));
   assign o_jump_pc    = pc_t'(o_inst_word[`FCPU_TARGET_W-1:0]);

   always_comb begin
      state_n = state;
      load    = 1'b0;
      o_pop   = 1'b0;
      case (state)
         issue_wait, issue_offer: begin
            if (state == issue_offer && !accept) begin
               // unaccepted offer dies on a core redirect
               if (i_redirect_valid) begin
                  state_n = issue_wait;
               end
            end else if (load_ok && !o_jump_valid) begin
               load    = 1'b1;
               o_pop   = 1'b1;
               state_n = issue_offer;
            end else if (i_head_valid && !i_head_live) begin
               state_n = issue_drop;
            end else begin
               state_n = issue_wait;
            end
         end
         issue_drop: begin
            // dead head, never shown to the core
            o_pop   = i_head_valid && !i_head_live;
            state_n = issue_wait;
         end
         default: begin
            state_n = issue_wait;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= issue_wait;
      end else begin
         state <= state_n;
      end
   end

   // core outputs hold while the offer stands
   always_ff @(posedge clk) begin
      if (load) begin
         o_inst_pc    <= i_head_pc;
         o_inst_word  <= i_head_word;
         o_inst_taken <= i_head_taken;
      end
   end

endmodule

//--- verilog/fcpu_fetch_top.sv
`timescale 1ns/100ps
`include "fcpu_settings.svh"

module fcpu_fetch_top (
   input  logic            clk,
   input  logic            nrst,
   // AXI4-Lite read address channel
   output logic [31:0]     o_cram_araddr,
   output logic [2:0]      o_cram_arprot,
   output logic            o_cram_arvalid,
   input  logic            i_cram_arready,
   // AXI4-Lite read data channel
   input  fcpu_pkg::inst_t i_cram_rdata,
   input  logic [1:0]      i_cram_rresp,
   input  logic            i_cram_rvalid,
   output logic            o_cram_rready,
   // core side
   output logic            o_inst_valid,
   output fcpu_pkg::pc_t   o_inst_pc,
   output fcpu_pkg::inst_t o_inst_word,
   output logic            o_inst_taken,
   input  logic            i_inst_ready,
   input  logic            i_redirect_valid,
   input  fcpu_pkg::pc_t   i_redirect_pc,
   input  logic            i_predict_taken
);
   import fcpu_pkg::*;

   pc_t   fetch_addr;
   logic  alloc_ok;
   logic  req_fire;
   logic  alloc_taken;
   logic  head_valid;
   logic  head_live;
   pc_t   head_pc;
   inst_t head_word;
   logic  head_taken;
   logic  pop;
   logic  jump_valid;
   pc_t   jump_pc;
   logic  flush;

   // code RAM never errors, rresp is left unread
   assign o_cram_araddr = {{(32 - `FCPU_ADDR_W){1'b0}}, fetch_addr};
   assign o_cram_arprot = 3'b000;

   // prediction travels with each read into its slot
   assign alloc_taken = i_predict_taken;
   assign flush       = i_redirect_valid | jump_valid;

   fetch_addr_gen fetch_addr_gen_i (
      .clk              (clk),
      .nrst             (nrst),
      .i_alloc_ok       (alloc_ok),
      .i_redirect_valid (i_redirect_valid),
      .i_redirect_pc    (i_redirect_pc),
      .i_jump_valid     (jump_valid),
      .i_jump_pc        (jump_pc),
      .o_cram_araddr    (fetch_addr),
      .o_cram_arvalid   (o_cram_arvalid),
      .i_cram_arready   (i_cram_arready),
      .o_req_fire       (req_fire)
   );

   fetch_queue fetch_queue_i (
      .clk           (clk),
      .nrst          (nrst),
      .i_req_fire    (req_fire),
      .i_req_pc      (fetch_addr),
      .i_req_taken   (alloc_taken),
      .i_cram_rdata  (i_cram_rdata),
      .i_cram_rvalid (i_cram_rvalid),
      .o_cram_rready (o_cram_rready),
      .i_flush       (flush),
      .i_pop         (pop),
      .o_alloc_ok    (alloc_ok),
      .o_head_valid  (head_valid),
      .o_head_live   (head_live),
      .o_head_pc     (head_pc),
      .o_head_word   (head_word),
      .o_head_taken  (head_taken)
   );

   inst_issue inst_issue_i (
      .clk              (clk),
      .nrst             (nrst),
      .i_head_valid     (head_valid),
      .i_head_live      (head_live),
      .i_head_pc        (head_pc),
      .i_head_word      (head_word),
      .i_head_taken     (head_taken),
      .o_pop            (pop),
      .o_inst_valid     (o_inst_valid),
      .o_inst_pc        (o_inst_pc),
      .o_inst_word      (o_inst_word),
      .o_inst_taken     (o_inst_taken),
      .i_inst_ready     (i_inst_ready),
      .i_redirect_valid (i_redirect_valid),
      .o_jump_valid     (jump_valid),
      .o_jump_pc        (jump_pc)
   );

endmodule

//--- sim/fetch_checker.sv
`timescale 1ns/100ps

module fetch_checker (
   input  logic            clk,
   input  logic            nrst,
   input  logic            i_inst_valid,
   input  logic            i_inst_ready,
   input  fcpu_pkg::pc_t   i_inst_pc,
   input  fcpu_pkg::inst_t i_inst_word,
   input  logic            i_inst_taken,
   input  logic            i_cram_arvalid,
   input  logic [2:0]      i_cram_arprot
);
   import fcpu_pkg::*;

   // expected triples packed as pc, word, taken
   logic [47:0] exp_q [$];
   logic [31:0] test_name;
   int          got;
   int          errs;
   int          pass_cnt = 0;
   int          fail_cnt = 0;

   task automatic begin_test(input logic [31:0] name);
      test_name = name;
      exp_q.delete();
      got  = 0;
      errs = 0;
   endtask

   task automatic add_expected(input pc_t pc, input inst_t word, input logic taken);
      exp_q.push_back({pc, word, taken});
   endtask

   always @(posedge clk) begin
      if (!nrst && i_inst_valid && i_inst_ready) begin
         if (got >= exp_q.size()) begin
            $display("test %s: extra instruction issued at pc %h", test_name, i_inst_pc);
            errs = errs + 1;
         end else if (exp_q[got] !== {i_inst_pc, i_inst_word, i_inst_taken}) begin
            $display("MISMATCH %s: expected pc %h word %h taken %b, actual pc %h word %h taken %b",
                     test_name, exp_q[got][47:33], exp_q[got][32:1], exp_q[got][0],
                     i_inst_pc, i_inst_word, i_inst_taken);
            errs = errs + 1;
         end
         got = got + 1;
      end
      // every read request goes out with arprot zero
      if (!nrst && i_cram_arvalid && i_cram_arprot !== 3'b000) begin
         $display("MISMATCH %s: expected arprot 000, actual arprot %b",
                  test_name, i_cram_arprot);
         errs = errs + 1;
      end
   end

   task automatic finish_test();
      if (got < exp_q.size()) begin
         $display("test %s: %0d of %0d expected instructions never issued",
                  test_name, exp_q.size() - got, exp_q.size());
         errs = errs + 1;
      end
      if (errs == 0) begin
         $display("test %s: ok, %0d instructions", test_name, got);
         pass_cnt = pass_cnt + 1;
      end else begin
         $display("test %s: FAILED with %0d errors", test_name, errs);
         fail_cnt = fail_cnt + 1;
      end
   endtask

   task automatic report_counts();
      $display("tests run %0d, passed %0d, failed %0d",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt);
   endtask

endmodule

//--- sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
   import fcpu_pkg::*;

   logic        clk;
   logic        nrst;
   logic [31:0] o_cram_araddr;
   logic [2:0]  o_cram_arprot;
   logic        o_cram_arvalid;
   logic        i_cram_arready;
   inst_t       i_cram_rdata;
   logic [1:0]  i_cram_rresp;
   logic        i_cram_rvalid;
   logic        o_cram_rready;
   logic        o_inst_valid;
   pc_t         o_inst_pc;
   inst_t       o_inst_word;
   logic        o_inst_taken;
   logic        i_inst_ready;
   logic        i_redirect_valid;
   pc_t         i_redirect_pc;
   logic        i_predict_taken;

   // vector file image and the current test's settings
   logic [31:0] vec [0:255];
   inst_t       prog [0:63];
   int          nprog;
   int          nexp;
   logic [31:0] stall_mask;
   logic        redir_en;
   pc_t         redir_x;
   pc_t         redir_y;
   logic [31:0] cur_name;

   // code RAM model and core model state
   integer      seed = 32'h460d_1572;
   logic [31:0] rsp_q [$];
   int          ar_delay;
   int          r_delay;
   int          acc_cnt;
   int          cyc;
   logic        redir_done;
   int          run_cycles;
   int          limit;

   fcpu_fetch_top fcpu_fetch_top_i (
      .clk              (clk),
      .nrst             (nrst),
      .o_cram_araddr    (o_cram_araddr),
      .o_cram_arprot    (o_cram_arprot),
      .o_cram_arvalid   (o_cram_arvalid),
      .i_cram_arready   (i_cram_arready),
      .i_cram_rdata     (i_cram_rdata),
      .i_cram_rresp     (i_cram_rresp),
      .i_cram_rvalid    (i_cram_rvalid),
      .o_cram_rready    (o_cram_rready),
      .o_inst_valid     (o_inst_valid),
      .o_inst_pc        (o_inst_pc),
      .o_inst_word      (o_inst_word),
      .o_inst_taken     (o_inst_taken),
      .i_inst_ready     (i_inst_ready),
      .i_redirect_valid (i_redirect_valid),
      .i_redirect_pc    (i_redirect_pc),
      .i_predict_taken  (i_predict_taken)
   );

   fetch_checker checker_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_inst_valid   (o_inst_valid),
      .i_inst_ready   (i_inst_ready),
      .i_inst_pc      (o_inst_pc),
      .i_inst_word    (o_inst_word),
      .i_inst_taken   (o_inst_taken),
      .i_cram_arvalid (o_cram_arvalid),
      .i_cram_arprot  (o_cram_arprot)
   );

   // words outside the program carry their own address
   function automatic inst_t code_word(input logic [31:0] addr);
      if ((addr >> 2) < nprog) begin
         return prog[addr >> 2];
      end
      return 32'hf000_0000 | addr;
   endfunction

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   always @(posedge clk) begin : cram_core_model
      logic accepted;
      int   next_cnt;
      logic trig;
      if (nrst) begin
         i_cram_arready   <= 1'b0;
         i_cram_rvalid    <= 1'b0;
         i_cram_rdata     <= '0;
         i_inst_ready     <= 1'b0;
         i_redirect_valid <= 1'b0;
         ar_delay         <= 0;
         r_delay          <= 0;
         acc_cnt          <= 0;
         cyc              <= 0;
         redir_done       <= 1'b0;
         rsp_q.delete();
      end else begin
         cyc <= cyc + 1;
         // AR accepted after 0 to 3 extra cycles
         if (o_cram_arvalid && i_cram_arready) begin
            rsp_q.push_back(o_cram_araddr);
            i_cram_arready <= 1'b0;
            ar_delay       <= $random(seed) & 3;
         end else if (o_cram_arvalid) begin
            if (ar_delay == 0) begin
               i_cram_arready <= 1'b1;
            end else begin
               ar_delay <= ar_delay - 1;
            end
         end
         // R returned in request order
         if (i_cram_rvalid && o_cram_rready) begin
            i_cram_rvalid <= 1'b0;
            r_delay       <= $random(seed) & 3;
         end else if (!i_cram_rvalid && rsp_q.size() > 0) begin
            if (r_delay == 0) begin
               i_cram_rvalid <= 1'b1;
               i_cram_rdata  <= code_word(rsp_q.pop_front());
            end else begin
               r_delay <= r_delay - 1;
            end
         end
         // core side stalls and the optional redirect
         accepted = o_inst_valid && i_inst_ready;
         next_cnt = acc_cnt + int'(accepted);
         acc_cnt <= next_cnt;
         trig = accepted && redir_en && !redir_done && (o_inst_pc == redir_x);
         if (trig) begin
            redir_done <= 1'b1;
         end
         i_redirect_valid <= trig;
         i_redirect_pc    <= redir_y;
         i_inst_ready     <= !trig && (next_cnt < nexp) && !stall_mask[5'(cyc + 1)];
      end
   end

   always @(posedge clk) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= limit) begin
         $display("timeout after %0d cycles, test %s issued %0d of %0d instructions",
                  run_cycles, cur_name, acc_cnt, nexp);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin : run_tests
      int ptr;
      int total;
      int base;
      nrst             = 1'b1;
      i_cram_arready   = 1'b0;
      i_cram_rdata     = '0;
      i_cram_rresp     = 2'b00;
      i_cram_rvalid    = 1'b0;
      i_inst_ready     = 1'b0;
      i_redirect_valid = 1'b0;
      i_redirect_pc    = '0;
      i_predict_taken  = 1'b0;
      run_cycles       = 0;
      limit            = 100;
      nexp             = 0;
      nprog            = 0;
      stall_mask       = '0;
      redir_en         = 1'b0;
      redir_x          = '0;
      redir_y          = '0;
      cur_name         = '0;
      $readmemh("sim/fetch_vectors.txt", vec);
      total = 0;
      ptr   = 0;
      while (vec[ptr] != 0) begin
         total = total + vec[ptr + 7];
         ptr   = ptr + 8 + vec[ptr + 1] + 3 * vec[ptr + 7];
      end
      limit = 40 * total + 100;
      ptr = 0;
      while (vec[ptr] != 0) begin
         @(posedge clk);
         nrst <= 1'b1;
         cur_name   = vec[ptr];
         nprog      = vec[ptr + 1];
         stall_mask = vec[ptr + 3];
         redir_en   = vec[ptr + 4][0];
         redir_x    = pc_t'(vec[ptr + 5]);
         redir_y    = pc_t'(vec[ptr + 6]);
         nexp       = vec[ptr + 7];
         i_predict_taken <= vec[ptr + 2][0];
         for (int k = 0; k < nprog; k++) begin
            prog[k] = vec[ptr + 8 + k];
         end
         checker_i.begin_test(cur_name);
         for (int k = 0; k < nexp; k++) begin
            base = ptr + 8 + nprog + 3 * k;
            checker_i.add_expected(pc_t'(vec[base]), vec[base + 1], vec[base + 2][0]);
         end
         repeat (4) @(posedge clk);
         nrst <= 1'b0;
         while (acc_cnt < nexp) begin
            @(posedge clk);
         end
         checker_i.finish_test();
         ptr = ptr + 8 + nprog + 3 * nexp;
      end
      checker_i.report_counts();
      if (checker_i.fail_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- sim/fetch_vectors.txt
// record: name(ascii) nprog predict stall_mask redir_en redir_x redir_y nexp
// then nprog words from pc 0, then nexp triples of pc word taken; name 0 ends
4c494e45 6 0 00000000 0 0 0 6
00000011 00000012 00000013 00000014 00000015 00000016
0 00000011 0  4 00000012 0  8 00000013 0
c 00000014 0  10 00000015 0  14 00000016 0
4a554d50 4 0 00000000 0 0 0 5
00000021 00000022 08000020 00000024
0 00000021 0  4 00000022 0  8 08000020 0
20 f0000020 0  24 f0000024 0
4252544b 4 1 00000000 0 0 0 5
00000031 00000032 10000040 00000034
0 00000031 1  4 00000032 1  8 10000040 1
40 f0000040 1  44 f0000044 1
42524e54 4 0 00000000 0 0 0 5
00000041 00000042 14000040 00000044
0 00000041 0  4 00000042 0  8 14000040 0
c 00000044 0  10 f0000010 0
52454452 4 0 00000000 1 8 50 5
00000051 00000052 00000053 00000054
0 00000051 0  4 00000052 0  8 00000053 0
50 f0000050 0  54 f0000054 0
5354414c 6 0 6c935a31 0 0 0 6
00000011 00000012 00000013 00000014 00000015 00000016
0 00000011 0  4 00000012 0  8 00000013 0
c 00000014 0  10 00000015 0  14 00000016 0
00000000

//--- files.f
+incdir+verilog
verilog/fcpu_pkg.sv
verilog/fetch_addr_gen.sv
verilog/fetch_queue.sv
verilog/inst_issue.sv
verilog/fcpu_fetch_top.sv
sim/fetch_checker.sv
sim/fetch_tb.sv
